// ==== flist.f ====
verilog/rv_isa_pkg.sv
verilog/id_bus_pkg.sv
verilog/id_inst_latch.sv
verilog/id_decoder.sv
verilog/id_gpr_file.sv
verilog/id_branch_unit.sv
verilog/id_issue_ctrl.sv
verilog/id_stage.sv
bench/id_stage_props.sv
bench/id_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f flist.f \
  --top-module id_stage_tb \
  -o id_stage_sim

./obj_dir/id_stage_sim | tee sim.log

if grep -q '^Verification passed$' sim.log; then
  echo "run.sh: simulation PASS"
else
  echo "run.sh: simulation FAIL"
  exit 1
fi

// ==== bench/id_stage_input.txt ====
# test fv inst pc es_allowin wb_wen wb_waddr wb_wdata hz_es hz_ms hz_ws stall chk (hex)
# expected: rd imm rs1data rs2data alu_op word gpr_wen invalid taken target (chk bits 0..6)
1 1 002082b3 100 1 0 0 0 0 0 0 0 3f 5 0 0 0 0 0 1 0 0 0
2 0 0 0 1 1 0 55 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 1 000002b3 104 1 0 0 0 0 0 0 0 3f 5 0 0 0 0 0 1 0 0 0
4 0 0 0 1 1 1 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 0 0 0 1 1 2 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
6 0 0 0 1 1 3 fffffffffffffff0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
7 0 0 0 1 1 4 80000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
8 1 fff08393 108 1 0 0 0 0 0 0 0 37 7 ffffffffffffffff 10 0 0 0 1 0 0 0
9 1 00208433 10c 1 0 0 0 0 0 0 0 3f 8 0 10 3 0 0 1 0 0 0
10 1 402184b3 110 1 0 0 0 0 0 0 0 3f 9 0 fffffffffffffff0 3 1 0 1 0 0 0
11 1 4042551b 114 1 0 0 0 0 0 0 0 37 a 404 80000000 0 7 1 1 0 0 0
12 1 123455b7 118 1 0 0 0 0 0 0 0 33 b 12345000 0 0 a 0 1 0 0 0
13 1 00108863 1000 1 0 0 0 0 0 0 0 7e 0 10 10 10 0 0 0 0 1 1010
14 1 00208863 1000 1 0 0 0 0 0 0 0 3e 0 10 10 3 0 0 0 0 0 0
15 1 fe11cce3 1000 1 0 0 0 0 0 0 0 7e 0 fffffffffffffff8 fffffffffffffff0 10 0 0 0 0 1 ff8
16 1 fe30cce3 1000 1 0 0 0 0 0 0 0 3e 0 fffffffffffffff8 10 fffffffffffffff0 0 0 0 0 0 0
17 1 100000ef 1000 1 0 0 0 0 0 0 0 73 1 100 0 0 0 0 1 0 1 1100
18 1 00508067 1000 1 0 0 0 0 0 0 0 77 0 5 10 0 0 0 1 0 1 14
19 1 00208633 11c 1 0 0 0 2 0 0 1 3f c 0 10 3 0 0 1 0 0 0
20 1 fff08393 120 1 0 0 0 1f 0 0 0 37 7 ffffffffffffffff 10 0 0 0 1 0 0 0
21 1 402184b3 124 0 0 0 0 0 0 0 0 3f 9 0 fffffffffffffff0 3 1 0 1 0 0 0
22 1 0000057f 128 1 0 0 0 0 0 0 0 33 a 0 0 0 0 0 0 1 0 0

// ==== bench/id_stage_tb.sv ====
// Decode stage testbench
`timescale 1ns/10ps
`default_nettype none

module id_stage_tb;

  logic                   clk;
  logic                   rst_n;
  logic                   fs_valid;
  id_bus_pkg::fs_to_ds_t  fs_to_ds;
  logic                   es_allowin;
  id_bus_pkg::wb_to_rf_t  wb_to_rf;
  id_bus_pkg::hazard_rd_t hazard_rd;
  logic                   o_ds_allowin;
  logic                   o_ds_to_es_valid;
  id_bus_pkg::ds_to_es_t  o_ds_to_es;
  id_bus_pkg::br_bus_t    o_br_bus;

  int          t_num;
  int          tests;
  int          passed;
  int          failed;
  int          errors;
  int          fd;
  int          status;
  string       line;
  // one vector, columns in file order
  logic [63:0] f_valid, f_inst, f_pc, f_esal, f_wen, f_waddr, f_wdata;
  logic [63:0] f_hze, f_hzm, f_hzw, f_stall, f_chk;
  logic [63:0] x_rd, x_imm, x_rs1, x_rs2, x_alu, x_word, x_gwen, x_inv, x_taken, x_target;

  id_stage id_stage_i (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_fs_to_ds_valid (fs_valid),
    .i_fs_to_ds       (fs_to_ds),
    .o_ds_allowin     (o_ds_allowin),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es       (o_ds_to_es),
    .o_br_bus         (o_br_bus),
    .i_wb_to_rf       (wb_to_rf),
    .i_hazard_rd      (hazard_rd)
  );

  always #4 clk = ~clk;

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: test %0d %s", $time, t_num, msg);
    errors++;
  endtask

  task automatic compare_field(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: test %0d %s is %0h, expected %0h", $time, t_num, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_outputs();
    rv_isa_pkg::opcode_t opcode;
    opcode = f_inst[6:0];
    compare_field("pc", o_ds_to_es.pc, f_pc);
    if (f_chk[0]) compare_field("rd", 64'(o_ds_to_es.rd), x_rd);
    if (f_chk[1]) compare_field("imm", o_ds_to_es.imm, x_imm);
    if (f_chk[2]) compare_field("rs1data", o_ds_to_es.rs1data, x_rs1);
    if (f_chk[3]) compare_field("rs2data", o_ds_to_es.rs2data, x_rs2);
    if (f_chk[4]) begin
      compare_field("alu_op", 64'(o_ds_to_es.alu_op), x_alu);
      compare_field("alu_word", 64'(o_ds_to_es.alu_word), x_word);
      compare_field("gpr_wen", 64'(o_ds_to_es.gpr_wen), x_gwen);
      compare_field("invalid", 64'(o_ds_to_es.invalid), x_inv);
      // jumps hand pc and 4 to execute for the link
      if (opcode == rv_isa_pkg::OPC_JAL || opcode == rv_isa_pkg::OPC_JALR) begin
        compare_field("alu_src1_pc", 64'(o_ds_to_es.alu_src1_pc), 64'd1);
        compare_field("alu_src2_sel", 64'(o_ds_to_es.alu_src2_sel),
                      64'(rv_isa_pkg::SRC2_FOUR));
      end
    end
    if (f_chk[5]) compare_field("taken", 64'(o_br_bus.taken), x_taken);
    if (f_chk[6]) compare_field("target", o_br_bus.target, x_target);
  endtask

  task automatic apply_vector();
    id_bus_pkg::ds_to_es_t held;
    int                    waited;
    @(negedge clk);
    fs_valid          = f_valid[0];
    fs_to_ds.inst     = f_inst[31:0];
    fs_to_ds.pc       = f_pc;
    es_allowin        = f_esal[0];
    wb_to_rf.wen      = f_wen[0];
    wb_to_rf.waddr    = f_waddr[4:0];
    wb_to_rf.wdata    = f_wdata;
    hazard_rd.es_rd   = f_hze[4:0];
    hazard_rd.ms_rd   = f_hzm[4:0];
    hazard_rd.ws_rd   = f_hzw[4:0];
    #2;
    if (f_valid[0] && !o_ds_allowin) begin
      $display("test %0d: the stage refused the fetched instruction", t_num);
      errors++;
    end
    @(negedge clk);  // accept and write edge done
    fs_valid     = 1'b0;
    wb_to_rf.wen = 1'b0;
    if (!f_valid[0]) begin
      #2;
      if (o_ds_to_es_valid || !o_ds_allowin) report_mismatch("stage busy after write-back");
      return;
    end
    if (f_stall[0]) begin
      repeat (3) begin
        #2;
        if (o_ds_to_es_valid || o_ds_allowin) report_mismatch("issued during hazard");
        @(negedge clk);
      end
      hazard_rd = '0;
    end
    waited = 0;
    #2;
    while (!o_ds_to_es_valid && waited < 20) begin
      @(negedge clk);
      #2;
      waited++;
    end
    if (!o_ds_to_es_valid) begin
      $display("timeout: test %0d did not issue within 20 cycles", t_num);
      errors++;
      hazard_rd  = '0;
      es_allowin = 1'b1;
      return;
    end
    check_outputs();
    if (!f_esal[0]) begin
      held = o_ds_to_es;
      repeat (3) begin
        @(negedge clk);
        #2;
        if (!o_ds_to_es_valid || o_ds_allowin || o_ds_to_es !== held) begin
          report_mismatch("outputs moved under back-pressure");
        end
      end
      @(negedge clk);
      es_allowin = 1'b1;
    end
    @(negedge clk);  // transfer edge done
    #2;
    if (o_ds_to_es_valid) report_mismatch("instruction issued more than once");
    hazard_rd = '0;
  endtask

  task automatic run_line(input string text);
    int n;
    int err_before;
    n = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                t_num, f_valid, f_inst, f_pc, f_esal, f_wen, f_waddr, f_wdata, f_hze, f_hzm,
                f_hzw, f_stall, f_chk, x_rd, x_imm, x_rs1, x_rs2, x_alu, x_word, x_gwen,
                x_inv, x_taken, x_target);
    if (n != 23) begin
      $display("a stimulus line could not be read: %s", text);
      errors++;
      return;
    end
    err_before = errors;
    apply_vector();
    tests++;
    if (errors == err_before) begin
      passed++;
      $display("test %0d ok", t_num);
    end else begin
      failed++;
      $display("test %0d FAILED", t_num);
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    fs_valid   = 1'b0;
    fs_to_ds   = '0;
    es_allowin = 1'b1;
    wb_to_rf   = '0;
    hazard_rd  = '0;
    t_num      = 0;
    tests      = 0;
    passed     = 0;
    failed     = 0;
    errors     = 0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    #2;
    if (!o_ds_allowin || o_ds_to_es_valid || o_br_bus.taken) begin
      report_mismatch("stage not empty after reset");
    end
    fd = $fopen("bench/id_stage_input.txt", "r");
    if (fd == 0) begin
      $display("the stimulus file bench/id_stage_input.txt could not be opened");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        status = $fgets(line, fd);
        if (status > 0 && line.len() > 1 && line.getc(0) != "#") run_line(line);  // skip notes
      end
      $fclose(fd);
    end
    $display("tests run %0d, ok %0d, failed %0d, errors %0d", tests, passed, failed, errors);
    if (errors == 0 && tests > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/id_stage_props.sv ====
// Decode stage handshake assertions
`timescale 1ns/10ps
`default_nettype none

module id_stage_props (
  input wire                   i_clk,
  input wire                   i_rst_n,
  input wire                   i_es_allowin,
  input wire                   i_ds_to_es_valid,
  input id_bus_pkg::ds_to_es_t i_ds_to_es,
  input id_bus_pkg::br_bus_t   i_br_bus
);

  // stage is empty when reset releases
  a_reset_empty: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_ds_to_es_valid)
    else $error("execute valid high at reset release");

  a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ds_to_es_valid && !i_es_allowin) |=> (i_ds_to_es_valid && $stable(i_ds_to_es)))
    else $error("execute bundle changed while execute was not ready");

  a_taken_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_bus.taken |-> i_ds_to_es_valid)  // redirect only with an issue
    else $error("redirect taken without execute valid");

endmodule

bind id_stage id_stage_props id_stage_props_i (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .i_es_allowin     (i_es_allowin),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_ds_to_es       (o_ds_to_es),
  .i_br_bus         (o_br_bus)
);

`default_nettype wire

// ==== verilog/id_stage.sv ====
// Instruction decode stage
`timescale 1ns/10ps
`default_nettype none

module id_stage (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  // fetch side
  input  wire                    i_fs_to_ds_valid,
  input  id_bus_pkg::fs_to_ds_t  i_fs_to_ds,
  output logic                   o_ds_allowin,
  // execute side
  input  wire                    i_es_allowin,
  output logic                   o_ds_to_es_valid,
  output id_bus_pkg::ds_to_es_t  o_ds_to_es,
  // redirect to fetch
  output id_bus_pkg::br_bus_t    o_br_bus,
  // write-back and hazard sources
  input  id_bus_pkg::wb_to_rf_t  i_wb_to_rf,
  input  id_bus_pkg::hazard_rd_t i_hazard_rd
);

  logic                  ds_valid;
  logic                  ready_go;
  id_bus_pkg::fs_to_ds_t ds_bundle;
  id_bus_pkg::dec_ctrl_t dec_ctrl;
  rv_isa_pkg::xlen_t     rs1data;
  rv_isa_pkg::xlen_t     rs2data;
  logic                  br_taken;
  rv_isa_pkg::xlen_t     br_target;

  id_inst_latch u_latch (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds       (i_fs_to_ds),
    .i_ready_go       (ready_go),
    .i_es_allowin     (i_es_allowin),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_valid       (ds_valid),
    .o_ds_bundle      (ds_bundle)
  );

  id_decoder u_dec (
    .i_inst (ds_bundle.inst),
    .o_ctrl (dec_ctrl)
  );

  id_gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (dec_ctrl.rs1),
    .i_raddr2 (dec_ctrl.rs2),
    .i_wb     (i_wb_to_rf),
    .o_rdata1 (rs1data),
    .o_rdata2 (rs2data)
  );

  id_branch_unit u_bru (
    .i_ctrl    (dec_ctrl),
    .i_pc      (ds_bundle.pc),
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .o_taken   (br_taken),
    .o_target  (br_target)
  );

  id_issue_ctrl u_issue (
    .i_ds_valid       (ds_valid),
    .i_ctrl           (dec_ctrl),
    .i_pc             (ds_bundle.pc),
    .i_rs1data        (rs1data),
    .i_rs2data        (rs2data),
    .i_taken          (br_taken),
    .i_target         (br_target),
    .i_hazard_rd      (i_hazard_rd),
    .o_ready_go       (ready_go),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es       (o_ds_to_es),
    .o_br_bus         (o_br_bus)
  );

endmodule

`default_nettype wire

// ==== verilog/id_issue_ctrl.sv ====
// Decode stage issue control
`timescale 1ns/10ps
`default_nettype none

module id_issue_ctrl (
  input  wire                    i_ds_valid,
  input  id_bus_pkg::dec_ctrl_t  i_ctrl,
  input  rv_isa_pkg::xlen_t      i_pc,
  input  rv_isa_pkg::xlen_t      i_rs1data,
  input  rv_isa_pkg::xlen_t      i_rs2data,
  input  wire                    i_taken,
  input  rv_isa_pkg::xlen_t      i_target,
  input  id_bus_pkg::hazard_rd_t i_hazard_rd,
  output logic                   o_ready_go,
  output logic                   o_ds_to_es_valid,
  output id_bus_pkg::ds_to_es_t  o_ds_to_es,
  output id_bus_pkg::br_bus_t    o_br_bus
);

  logic is_link;

  // a used nonzero source matching any pending destination
  function automatic logic src_hit(
    input logic                   used,
    input rv_isa_pkg::gpr_addr_t  src,
    input id_bus_pkg::hazard_rd_t hz
  );
    logic hit;
    hit = (hz.es_rd == src) || (hz.ms_rd == src) || (hz.ws_rd == src);
    return used && (src != '0) && hit;
  endfunction

  assign o_ready_go = !(src_hit(i_ctrl.rs1_used, i_ctrl.rs1, i_hazard_rd) ||
                        src_hit(i_ctrl.rs2_used, i_ctrl.rs2, i_hazard_rd));

  assign o_ds_to_es_valid = i_ds_valid && o_ready_go;

  assign o_br_bus.taken  = o_ds_to_es_valid && i_taken;
  assign o_br_bus.target = i_target;

  // jumps hand pc + 4 to execute as the link value
  assign is_link = i_ctrl.is_jal || i_ctrl.is_jalr;

  assign o_ds_to_es.rs1data      = i_rs1data;
  assign o_ds_to_es.rs2data      = i_rs2data;
  assign o_ds_to_es.imm          = i_ctrl.imm;
  assign o_ds_to_es.pc           = i_pc;
  assign o_ds_to_es.alu_src1_pc  = is_link || i_ctrl.alu_src1_pc;
  assign o_ds_to_es.alu_src2_sel = is_link ? rv_isa_pkg::SRC2_FOUR : i_ctrl.alu_src2_sel;
  assign o_ds_to_es.alu_op       = i_ctrl.alu_op;
  assign o_ds_to_es.alu_word     = i_ctrl.alu_word;
  assign o_ds_to_es.rd           = i_ctrl.rd;
  assign o_ds_to_es.gpr_wen      = i_ctrl.gpr_wen;
  assign o_ds_to_es.mem_ren      = i_ctrl.mem_ren;
  assign o_ds_to_es.mem_wen      = i_ctrl.mem_wen;
  assign o_ds_to_es.mem_op       = i_ctrl.mem_op;
  assign o_ds_to_es.invalid      = i_ctrl.invalid;

endmodule

`default_nettype wire

// ==== verilog/id_branch_unit.sv ====
// Branch and jump resolution
`timescale 1ns/10ps
`default_nettype none

module id_branch_unit (
  input  id_bus_pkg::dec_ctrl_t i_ctrl,
  input  rv_isa_pkg::xlen_t     i_pc,
  input  rv_isa_pkg::xlen_t     i_rs1data,
  input  rv_isa_pkg::xlen_t     i_rs2data,
  output logic                  o_taken,
  output rv_isa_pkg::xlen_t     o_target
);

  logic              eq;
  logic              lt_s;
  logic              lt_u;
  logic              cond;
  rv_isa_pkg::xlen_t jalr_sum;

  assign eq   = (i_rs1data == i_rs2data);
  assign lt_s = ($signed(i_rs1data) < $signed(i_rs2data));
  assign lt_u = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_ctrl.br_func)
      rv_isa_pkg::BR_BEQ:  cond = eq;
      rv_isa_pkg::BR_BNE:  cond = !eq;
      rv_isa_pkg::BR_BLT:  cond = lt_s;
      rv_isa_pkg::BR_BGE:  cond = !lt_s;
      rv_isa_pkg::BR_BLTU: cond = lt_u;
      rv_isa_pkg::BR_BGEU: cond = !lt_u;
      default:             cond = 1'b0;  // reserved, decoder flags it
    endcase
  end

  assign jalr_sum = i_rs1data + i_ctrl.imm;

  assign o_taken = i_ctrl.is_jal || i_ctrl.is_jalr || (i_ctrl.is_branch && cond);

  // jalr clears bit 0 of the sum
  assign o_target = i_ctrl.is_jalr ? {jalr_sum[rv_isa_pkg::XLEN-1:1], 1'b0}
                                   : i_pc + i_ctrl.imm;

endmodule

`default_nettype wire

// ==== verilog/id_gpr_file.sv ====
// General purpose register file
`timescale 1ns/10ps
`default_nettype none

module id_gpr_file (
  input  wire                   i_clk,
  input  wire                   i_rst_n,
  input  rv_isa_pkg::gpr_addr_t i_raddr1,
  input  rv_isa_pkg::gpr_addr_t i_raddr2,
  input  id_bus_pkg::wb_to_rf_t i_wb,
  output rv_isa_pkg::xlen_t     o_rdata1,
  output rv_isa_pkg::xlen_t     o_rdata2
);

  rv_isa_pkg::xlen_t gpr_q [rv_isa_pkg::NUM_GPR];

  // entry 0 is never written
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < rv_isa_pkg::NUM_GPR; i++) begin
        gpr_q[i] <= '0;
      end
    end else if (i_wb.wen && (i_wb.waddr != '0)) begin
      gpr_q[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // no write-through, new value seen next cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : gpr_q[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : gpr_q[i_raddr2];

endmodule

`default_nettype wire

// ==== verilog/id_decoder.sv ====
// RV64I instruction decoder
`timescale 1ns/10ps
`default_nettype none

module id_decoder (
  input  rv_isa_pkg::inst_t     i_inst,
  output id_bus_pkg::dec_ctrl_t o_ctrl
);

  rv_isa_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [6:0]          shift_f;  // upper field of immediate shifts
  rv_isa_pkg::xlen_t   imm_i;
  rv_isa_pkg::xlen_t   imm_s;
  rv_isa_pkg::xlen_t   imm_b;
  rv_isa_pkg::xlen_t   imm_u;
  rv_isa_pkg::xlen_t   imm_j;
  logic                bad;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // rv64 shamt is 6 bits, word shifts keep the full funct7
  assign shift_f = (opcode == rv_isa_pkg::OPC_OP_IMM32) ? funct7 : {i_inst[31:26], 1'b0};

  always_comb begin
    o_ctrl              = '0;
    bad                 = 1'b0;
    o_ctrl.rs1          = i_inst[19:15];
    o_ctrl.rs2          = i_inst[24:20];
    o_ctrl.rd           = i_inst[11:7];
    o_ctrl.mem_op       = funct3;
    o_ctrl.br_func      = funct3;
    o_ctrl.alu_op       = rv_isa_pkg::ALU_ADD;
    o_ctrl.alu_src2_sel = rv_isa_pkg::SRC2_RS2;
    case (opcode)
      rv_isa_pkg::OPC_LUI: begin
        o_ctrl.imm          = imm_u;
        o_ctrl.alu_op       = rv_isa_pkg::ALU_LUI;
        o_ctrl.alu_src2_sel = rv_isa_pkg::SRC2_IMM;
        o_ctrl.gpr_wen      = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        o_ctrl.imm          = imm_u;
        o_ctrl.alu_src1_pc  = 1'b1;
        o_ctrl.alu_src2_sel = rv_isa_pkg::SRC2_IMM;
        o_ctrl.gpr_wen      = 1'b1;
      end
      rv_isa_pkg::OPC_JAL: begin
        o_ctrl.imm     = imm_j;
        o_ctrl.is_jal  = 1'b1;
        o_ctrl.gpr_wen = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        o_ctrl.imm      = imm_i;
        o_ctrl.rs1_used = 1'b1;
        o_ctrl.is_jalr  = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        bad             = (funct3 != 3'b000);
      end
      rv_isa_pkg::OPC_BRANCH: begin
        o_ctrl.imm       = imm_b;
        o_ctrl.rs1_used  = 1'b1;
        o_ctrl.rs2_used  = 1'b1;
        o_ctrl.is_branch = 1'b1;
        bad              = (funct3[2:1] == 2'b01);  // 010, 011 reserved
      end
      rv_isa_pkg::OPC_LOAD: begin
        o_ctrl.imm          = imm_i;
        o_ctrl.rs1_used     = 1'b1;
        o_ctrl.alu_src2_sel = rv_isa_pkg::SRC2_IMM;
        o_ctrl.mem_ren      = 1'b1;
        o_ctrl.gpr_wen      = 1'b1;
        bad                 = (funct3 == 3'b111);
      end
      rv_isa_pkg::OPC_STORE: begin
        o_ctrl.imm          = imm_s;
        o_ctrl.rs1_used     = 1'b1;
        o_ctrl.rs2_used     = 1'b1;
        o_ctrl.alu_src2_sel = rv_isa_pkg::SRC2_IMM;
        o_ctrl.mem_wen      = 1'b1;
        bad                 = funct3[2];  // sb sh sw sd only
      end
      rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP_IMM32: begin
        o_ctrl.imm          = imm_i;
        o_ctrl.rs1_used     = 1'b1;
        o_ctrl.alu_src2_sel = rv_isa_pkg::SRC2_IMM;
        o_ctrl.alu_word     = (opcode == rv_isa_pkg::OPC_OP_IMM32);
        o_ctrl.gpr_wen      = 1'b1;
        case (funct3)
          3'b000: o_ctrl.alu_op = rv_isa_pkg::ALU_ADD;
          3'b001: begin
            o_ctrl.alu_op = rv_isa_pkg::ALU_SLL;
            bad           = (shift_f != 7'b0000000);
          end
          3'b101: begin
            o_ctrl.alu_op = shift_f[5] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            bad           = (shift_f != 7'b0000000) && (shift_f != 7'b0100000);
          end
          3'b010: o_ctrl.alu_op = rv_isa_pkg::ALU_SLT;
          3'b011: o_ctrl.alu_op = rv_isa_pkg::ALU_SLTU;
          3'b100: o_ctrl.alu_op = rv_isa_pkg::ALU_XOR;
          3'b110: o_ctrl.alu_op = rv_isa_pkg::ALU_OR;
          default: o_ctrl.alu_op = rv_isa_pkg::ALU_AND;
        endcase
        // word form has only addiw, slliw, srliw, sraiw
        if (o_ctrl.alu_word && (funct3 != 3'b000) && (funct3[1:0] != 2'b01)) begin
          bad = 1'b1;
        end
      end
      rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP32: begin
        o_ctrl.rs1_used = 1'b1;
        o_ctrl.rs2_used = 1'b1;
        o_ctrl.alu_word = (opcode == rv_isa_pkg::OPC_OP32);
        o_ctrl.gpr_wen  = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: o_ctrl.alu_op = rv_isa_pkg::ALU_ADD;
          10'b0100000_000: o_ctrl.alu_op = rv_isa_pkg::ALU_SUB;
          10'b0000000_001: o_ctrl.alu_op = rv_isa_pkg::ALU_SLL;
          10'b0000000_101: o_ctrl.alu_op = rv_isa_pkg::ALU_SRL;
          10'b0100000_101: o_ctrl.alu_op = rv_isa_pkg::ALU_SRA;
          10'b0000000_010: o_ctrl.alu_op = rv_isa_pkg::ALU_SLT;
          10'b0000000_011: o_ctrl.alu_op = rv_isa_pkg::ALU_SLTU;
          10'b0000000_100: o_ctrl.alu_op = rv_isa_pkg::ALU_XOR;
          10'b0000000_110: o_ctrl.alu_op = rv_isa_pkg::ALU_OR;
          10'b0000000_111: o_ctrl.alu_op = rv_isa_pkg::ALU_AND;
          default:         bad = 1'b1;
        endcase
        if (o_ctrl.alu_word && (funct3 != 3'b000) && (funct3[1:0] != 2'b01)) begin
          bad = 1'b1;  // no word form of slt/sltu/xor/or/and
        end
      end
      default: bad = 1'b1;
    endcase

    // invalid still issues, but with no side effects
    if (bad) begin
      o_ctrl.invalid   = 1'b1;
      o_ctrl.gpr_wen   = 1'b0;
      o_ctrl.mem_ren   = 1'b0;
      o_ctrl.mem_wen   = 1'b0;
      o_ctrl.is_branch = 1'b0;
      o_ctrl.is_jal    = 1'b0;
      o_ctrl.is_jalr   = 1'b0;
      o_ctrl.rs1_used  = 1'b0;
      o_ctrl.rs2_used  = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/id_inst_latch.sv ====
// Decode stage input latch
`timescale 1ns/10ps
`default_nettype none

module id_inst_latch (
  input  wire                   i_clk,
  input  wire                   i_rst_n,
  // from fetch
  input  wire                   i_fs_to_ds_valid,
  input  id_bus_pkg::fs_to_ds_t i_fs_to_ds,
  // issue side
  input  wire                   i_ready_go,
  input  wire                   i_es_allowin,
  output logic                  o_ds_allowin,
  output logic                  o_ds_valid,
  output id_bus_pkg::fs_to_ds_t o_ds_bundle
);

  logic ds_valid_q;
  logic accept;

  // empty, or current instruction leaves this cycle
  assign o_ds_allowin = !ds_valid_q || (i_ready_go && i_es_allowin);
  assign accept       = i_fs_to_ds_valid && o_ds_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid_q <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid_q <= i_fs_to_ds_valid;  // bubble when fetch has nothing
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ds_bundle <= '0;
    end else if (accept) begin
      o_ds_bundle <= i_fs_to_ds;
    end
  end

  assign o_ds_valid = ds_valid_q;

endmodule

`default_nettype wire

// ==== verilog/id_bus_pkg.sv ====
// Decode stage bus structures
`default_nettype none

package id_bus_pkg;

  // fetch to decode
  typedef struct packed {
    rv_isa_pkg::inst_t inst;
    rv_isa_pkg::xlen_t pc;
  } fs_to_ds_t;

  // write-back to register file
  typedef struct packed {
    logic                  wen;
    rv_isa_pkg::gpr_addr_t waddr;
    rv_isa_pkg::xlen_t     wdata;
  } wb_to_rf_t;

  typedef struct packed {
    rv_isa_pkg::gpr_addr_t rs1;
    rv_isa_pkg::gpr_addr_t rs2;
    logic                  rs1_used;
    logic                  rs2_used;
    rv_isa_pkg::gpr_addr_t rd;
    rv_isa_pkg::xlen_t     imm;
    logic                  alu_src1_pc;
    rv_isa_pkg::src2_sel_t alu_src2_sel;
    logic                  alu_word;  // 32-bit op, sign-extend result
    rv_isa_pkg::alu_op_t   alu_op;
    logic                  gpr_wen;
    logic                  mem_ren;
    logic                  mem_wen;
    rv_isa_pkg::mem_op_t   mem_op;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    rv_isa_pkg::br_func_t  br_func;
    logic                  invalid;
  } dec_ctrl_t;

  // decode to execute
  typedef struct packed {
    rv_isa_pkg::xlen_t     rs1data;
    rv_isa_pkg::xlen_t     rs2data;
    rv_isa_pkg::xlen_t     imm;
    rv_isa_pkg::xlen_t     pc;
    logic                  alu_src1_pc;
    rv_isa_pkg::src2_sel_t alu_src2_sel;
    rv_isa_pkg::alu_op_t   alu_op;
    logic                  alu_word;
    rv_isa_pkg::gpr_addr_t rd;
    logic                  gpr_wen;
    logic                  mem_ren;
    logic                  mem_wen;
    rv_isa_pkg::mem_op_t   mem_op;
    logic                  invalid;
  } ds_to_es_t;

  // redirect to fetch
  typedef struct packed {
    logic              taken;
    rv_isa_pkg::xlen_t target;
  } br_bus_t;

  // destinations of execute, memory and write-back stages
  typedef struct packed {
    rv_isa_pkg::gpr_addr_t es_rd;
    rv_isa_pkg::gpr_addr_t ms_rd;
    rv_isa_pkg::gpr_addr_t ws_rd;
  } hazard_rd_t;

endpackage

`default_nettype wire

// ==== verilog/rv_isa_pkg.sv ====
// RV64I ISA definitions
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int NUM_GPR     = 32;

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [INST_WD-1:0]     inst_t;
  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [6:0]             opcode_t;
  typedef logic [4:0]             alu_op_t;
  typedef logic [2:0]             br_func_t;
  typedef logic [2:0]             mem_op_t;  // funct3 of load/store
  typedef logic [1:0]             src2_sel_t;

  // major opcodes
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_AUIPC    = 7'b0010111;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_LOAD     = 7'b0000011;
  localparam opcode_t OPC_STORE    = 7'b0100011;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_OP_IMM32 = 7'b0011011;
  localparam opcode_t OPC_OP32     = 7'b0111011;

  localparam alu_op_t ALU_ADD  = 5'd0;
  localparam alu_op_t ALU_SUB  = 5'd1;
  localparam alu_op_t ALU_SLL  = 5'd2;
  localparam alu_op_t ALU_SLT  = 5'd3;
  localparam alu_op_t ALU_SLTU = 5'd4;
  localparam alu_op_t ALU_XOR  = 5'd5;
  localparam alu_op_t ALU_SRL  = 5'd6;
  localparam alu_op_t ALU_SRA  = 5'd7;
  localparam alu_op_t ALU_OR   = 5'd8;
  localparam alu_op_t ALU_AND  = 5'd9;
  localparam alu_op_t ALU_LUI  = 5'd10;  // pass operand 2

  localparam br_func_t BR_BEQ  = 3'b000;
  localparam br_func_t BR_BNE  = 3'b001;
  localparam br_func_t BR_BLT  = 3'b100;
  localparam br_func_t BR_BGE  = 3'b101;
  localparam br_func_t BR_BLTU = 3'b110;
  localparam br_func_t BR_BGEU = 3'b111;

  // alu operand 2 select
  localparam src2_sel_t SRC2_RS2  = 2'd0;
  localparam src2_sel_t SRC2_IMM  = 2'd1;
  localparam src2_sel_t SRC2_FOUR = 2'd2;  // link value pc + 4

endpackage

`default_nettype wire
